// File: verilog/hart_params.svh
`ifndef HART_PARAMS_SVH
`define HART_PARAMS_SVH

// datapath and address width of the hart
`define XLEN 32

// register file address width, 32 architectural registers
`define REG_AW 5

// address of the first fetch once reset is released
`define RESET_ADDR 32'h0000_0000

// ebreak ends the program and retires with halt set
`define EBREAK_INST 32'h0010_0073

// addi x0, x0, 0 which fills the IF/ID register when no word is fetched
`define NOP_INST 32'h0000_0013

`endif

// File: verilog/isa_pkg.sv
`include "hart_params.svh"

package isa_pkg;

  // major opcodes of the subset, everything else decodes as a no-op
  typedef enum logic [6:0] {
    OP     = 7'b0110011, // register-register ALU
    OP_IMM = 7'b0010011, // register-immediate ALU
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011, // lw only
    STORE  = 7'b0100011, // sw only
    SYSTEM = 7'b1110011  // ebreak
  } opcode_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLTU,
    SLL,
    SRL,
    SRA,
    PASS_B // operand b straight through, lui uses it with the U immediate
  } alu_op_e;

  typedef enum logic {
    ALU, // result of the execute stage
    MEM  // word returned by the data memory
  } wb_sel_e;

  // field view of one instruction word, msb first
  typedef struct packed {
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    opcode_e            opcode;
  } rv_inst_t;

  // lui and ebreak carry no rs1, their bits there belong to other fields
  function automatic logic uses_rs1(input opcode_e op);
    return op inside {OP, OP_IMM, LOAD, STORE};
  endfunction

  // only register-register ops and stores read rs2
  function automatic logic uses_rs2(input opcode_e op);
    return op inside {OP, STORE};
  endfunction

endpackage

// File: verilog/pipe_pkg.sv
`include "hart_params.svh"

package pipe_pkg;
  import isa_pkg::*;

  // fetched word with its address
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    rv_inst_t         inst;
  } if_id_t;

  // decoded instruction with its register reads and control
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    rv_inst_t         inst;
    logic [`XLEN-1:0] rs1_val;   // zero when rs1 is not read
    logic [`XLEN-1:0] rs2_val;   // zero when rs2 is not read
    logic [`XLEN-1:0] imm;
    alu_op_e          alu_op;
    logic             use_imm;   // operand b is imm rather than rs2
    logic             reg_write;
    logic             mem_read;
    logic             mem_write;
    wb_sel_e          wb_sel;
    logic             halt;      // set for ebreak
  } id_ex_t;

  // executed instruction heading for the data memory
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    rv_inst_t         inst;
    logic [`XLEN-1:0] rs1_val;   // operands after forwarding
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] alu_result; // also the data memory address
    logic [`XLEN-1:0] store_data;
    logic             reg_write;
    logic             mem_read;
    logic             mem_write;
    wb_sel_e          wb_sel;
    logic             halt;
  } ex_mem_t;

  // one retired instruction as seen at the hart boundary
  typedef struct packed {
    logic               valid;
    logic               halt;
    logic [`XLEN-1:0]   inst;
    logic [`XLEN-1:0]   pc;
    logic [`REG_AW-1:0] rd_addr;  // zero when nothing is written
    logic [`XLEN-1:0]   rd_data;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic [`XLEN-1:0]   dmem_addr;
    logic               dmem_ren;
    logic               dmem_wen;
  } retire_t;

endpackage

// File: verilog/fetch_stage.sv
`timescale 1ns/100ps
`include "hart_params.svh"

module fetch_stage (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_stall,      // decode keeps its instruction one more cycle
  input  logic             i_halt_seen,  // ebreak decoded, nothing younger may issue
  input  logic [`XLEN-1:0] i_imem_rdata, // word for the address presented last cycle
  output logic [`XLEN-1:0] o_imem_raddr,
  output pipe_pkg::if_id_t o_if_id
);
  import pipe_pkg::*;

  logic [`XLEN-1:0] pc_q;    // address of the word arriving on i_imem_rdata now
  logic             first_q; // first cycle out of reset, rdata belongs to no request
  logic             advance;
  logic             fill;    // the arriving word enters IF/ID as a real instruction
  if_id_t           if_id_q;

  assign advance = !first_q && !i_stall && !i_halt_seen;
  assign fill    = !first_q && !i_halt_seen;

  // the next address goes out now so the synchronous read lines up with the IF/ID edge
  // on a stall the same address is read again and the word is taken a cycle later
  assign o_imem_raddr = advance ? pc_q + `XLEN'd4 : pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q          <= `RESET_ADDR;
      first_q       <= 1'b1;
      if_id_q.valid <= 1'b0;
    end else begin
      pc_q    <= o_imem_raddr;
      first_q <= 1'b0;
      if (!i_stall) begin // a stall holds IF/ID as it is
        if_id_q.valid <= fill;
        if_id_q.pc    <= pc_q;
        if_id_q.inst  <= fill ? i_imem_rdata : `NOP_INST; // bubbles carry a nop
      end
    end
  end

  assign o_if_id = if_id_q;

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/100ps
`include "hart_params.svh"

module decode_stage (
  input  logic               i_clk,
  input  logic               i_rst,
  input  pipe_pkg::if_id_t   i_if_id,
  input  logic [`REG_AW-1:0] i_ex_rd,       // destination of the instruction in EX
  input  logic               i_ex_mem_read, // that instruction is a valid load
  input  logic               i_wb_valid,    // register write from writeback this cycle
  input  logic [`REG_AW-1:0] i_wb_addr,
  input  logic [`XLEN-1:0]   i_wb_data,
  output logic               o_stall,
  output logic               o_halt_seen,
  output pipe_pkg::id_ex_t   o_id_ex
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [`XLEN-1:0]   regs [32]; // entry 0 is never written, x0 reads as zero
  rv_inst_t           inst;
  logic [`REG_AW-1:0] rs1_addr;  // zero when the source is not read
  logic [`REG_AW-1:0] rs2_addr;
  logic [`XLEN-1:0]   rs1_val;
  logic [`XLEN-1:0]   rs2_val;
  logic               halt_q;    // an ebreak has gone down the pipe
  id_ex_t             id_ex_d;
  id_ex_t             id_ex_q;

  // alt selects sub and sra, callers mask it for immediate ops
  function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return alt ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  assign inst     = i_if_id.inst;
  assign rs1_addr = uses_rs1(inst.opcode) ? inst.rs1 : '0;
  assign rs2_addr = uses_rs2(inst.opcode) ? inst.rs2 : '0;

  // write-first read, the word retiring this cycle is seen straight away
  assign rs1_val = (rs1_addr == '0) ? '0 :
                   (i_wb_valid && i_wb_addr == rs1_addr) ? i_wb_data : regs[rs1_addr];
  assign rs2_val = (rs2_addr == '0) ? '0 :
                   (i_wb_valid && i_wb_addr == rs2_addr) ? i_wb_data : regs[rs2_addr];

  // a load's word is only on hand in writeback, so its consumer waits one cycle
  assign o_stall = i_if_id.valid && i_ex_mem_read && i_ex_rd != '0 &&
                   (rs1_addr == i_ex_rd || rs2_addr == i_ex_rd);

  // fetch must freeze in the same cycle the ebreak is decoded
  assign o_halt_seen = halt_q || (i_if_id.valid && id_ex_d.halt);

  always_comb begin
    id_ex_d           = '0;
    id_ex_d.valid     = i_if_id.valid && !o_stall && !halt_q; // a stall sends a bubble
    id_ex_d.pc        = i_if_id.pc;
    id_ex_d.inst      = inst;
    id_ex_d.rs1_val   = rs1_val;
    id_ex_d.rs2_val   = rs2_val;
    id_ex_d.imm       = {{20{inst.funct7[6]}}, inst.funct7, inst.rs2}; // I form
    id_ex_d.alu_op    = ADD;
    id_ex_d.wb_sel    = ALU;
    case (inst.opcode)
      OP: begin
        id_ex_d.alu_op    = alu_decode(inst.funct3, inst.funct7[5]);
        id_ex_d.reg_write = 1'b1;
      end
      OP_IMM: begin
        // bit 30 is part of the immediate except for srai
        id_ex_d.alu_op    = alu_decode(inst.funct3, inst.funct3 == 3'b101 && inst.funct7[5]);
        id_ex_d.use_imm   = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      LUI: begin
        id_ex_d.imm       = {inst.funct7, inst.rs2, inst.rs1, inst.funct3, 12'b0};
        id_ex_d.alu_op    = PASS_B;
        id_ex_d.use_imm   = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      LOAD: begin
        id_ex_d.use_imm   = 1'b1; // address is rs1 plus the I immediate
        id_ex_d.reg_write = 1'b1;
        id_ex_d.mem_read  = 1'b1;
        id_ex_d.wb_sel    = MEM;
      end
      STORE: begin
        id_ex_d.imm       = {{20{inst.funct7[6]}}, inst.funct7, inst.rd}; // S form
        id_ex_d.use_imm   = 1'b1;
        id_ex_d.mem_write = 1'b1;
      end
      SYSTEM:  id_ex_d.halt = (i_if_id.inst == `EBREAK_INST);
      default: ; // unknown opcodes retire without any effect
    endcase
  end

  // the register file starts from zero so programs may read any register
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_valid && i_wb_addr != '0) begin
      regs[i_wb_addr] <= i_wb_data; // same edge that ends the retire cycle
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      halt_q        <= 1'b0;
      id_ex_q.valid <= 1'b0;
    end else begin
      halt_q  <= o_halt_seen; // sticky until the next reset
      id_ex_q <= id_ex_d;
    end
  end

  assign o_id_ex = id_ex_q;

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/100ps
`include "hart_params.svh"

module execute_stage (
  input  logic               i_clk,
  input  logic               i_rst,
  input  pipe_pkg::id_ex_t   i_id_ex,
  input  logic               i_wb_valid, // second forwarding source
  input  logic [`REG_AW-1:0] i_wb_addr,
  input  logic [`XLEN-1:0]   i_wb_data,
  output logic [`REG_AW-1:0] o_ex_rd,       // for the load-use check in decode
  output logic               o_ex_mem_read,
  output pipe_pkg::ex_mem_t  o_ex_mem
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [`REG_AW-1:0] rs1_addr;
  logic [`REG_AW-1:0] rs2_addr;
  logic               mem_fwd;    // EX/MEM holds a result that may be forwarded
  logic [`XLEN-1:0]   src1;
  logic [`XLEN-1:0]   src2;
  logic [`XLEN-1:0]   op_b;
  logic [`XLEN-1:0]   alu_result;
  ex_mem_t            ex_mem_q;

  // youngest producer wins, EX/MEM first and then writeback
  function automatic logic [`XLEN-1:0] fwd(input logic [`REG_AW-1:0] addr,
                                          input logic [`XLEN-1:0]   dec_val);
    if (addr == '0) return '0; // x0 and unread sources stay zero
    if (mem_fwd && ex_mem_q.inst.rd == addr) return ex_mem_q.alu_result;
    if (i_wb_valid && i_wb_addr == addr) return i_wb_data;
    return dec_val;
  endfunction

  assign rs1_addr = uses_rs1(i_id_ex.inst.opcode) ? i_id_ex.inst.rs1 : '0;
  assign rs2_addr = uses_rs2(i_id_ex.inst.opcode) ? i_id_ex.inst.rs2 : '0;

  // a load in EX/MEM has no data yet, decode stalls its consumer instead
  assign mem_fwd = ex_mem_q.valid && ex_mem_q.reg_write && !ex_mem_q.mem_read;

  always_comb begin
    src1 = fwd(rs1_addr, i_id_ex.rs1_val);
    src2 = fwd(rs2_addr, i_id_ex.rs2_val);
    op_b = i_id_ex.use_imm ? i_id_ex.imm : src2;
    case (i_id_ex.alu_op)
      ADD:     alu_result = src1 + op_b; // also loads and stores
      SUB:     alu_result = src1 - op_b;
      AND:     alu_result = src1 & op_b;
      OR:      alu_result = src1 | op_b;
      XOR:     alu_result = src1 ^ op_b;
      SLT:     alu_result = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(op_b)};
      SLTU:    alu_result = {{(`XLEN-1){1'b0}}, src1 < op_b};
      SLL:     alu_result = src1 << op_b[4:0];
      SRL:     alu_result = src1 >> op_b[4:0];
      SRA:     alu_result = $signed(src1) >>> op_b[4:0];
      PASS_B:  alu_result = op_b;
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ex_mem_q.valid <= 1'b0;
    end else begin
      ex_mem_q.valid      <= i_id_ex.valid;
      ex_mem_q.pc         <= i_id_ex.pc;
      ex_mem_q.inst       <= i_id_ex.inst;
      ex_mem_q.rs1_val    <= src1;
      ex_mem_q.rs2_val    <= src2;
      ex_mem_q.alu_result <= alu_result;
      ex_mem_q.store_data <= src2; // sw writes the forwarded rs2
      ex_mem_q.reg_write  <= i_id_ex.reg_write;
      ex_mem_q.mem_read   <= i_id_ex.mem_read;
      ex_mem_q.mem_write  <= i_id_ex.mem_write;
      ex_mem_q.wb_sel     <= i_id_ex.wb_sel;
      ex_mem_q.halt       <= i_id_ex.halt;
    end
  end

  assign o_ex_rd       = i_id_ex.inst.rd;
  assign o_ex_mem_read = i_id_ex.valid && i_id_ex.mem_read;
  assign o_ex_mem      = ex_mem_q;

endmodule

// File: verilog/mem_wb_stage.sv
`timescale 1ns/100ps
`include "hart_params.svh"

module mem_wb_stage (
  input  logic               i_clk,
  input  logic               i_rst,
  input  pipe_pkg::ex_mem_t  i_ex_mem,
  input  logic [`XLEN-1:0]   i_dmem_rdata, // answers the read issued one cycle earlier
  output logic [`XLEN-1:0]   o_dmem_addr,
  output logic               o_dmem_ren,
  output logic               o_dmem_wen,
  output logic [`XLEN-1:0]   o_dmem_wdata,
  output logic               o_wb_valid,
  output logic [`REG_AW-1:0] o_wb_addr,
  output logic [`XLEN-1:0]   o_wb_data,
  output pipe_pkg::retire_t  o_retire
);
  import isa_pkg::*;
  import pipe_pkg::*;

  ex_mem_t mem_wb_q; // the instruction retiring this cycle

  // word accesses only, the ALU sum is already the aligned address
  assign o_dmem_addr  = i_ex_mem.alu_result;
  assign o_dmem_ren   = i_ex_mem.valid && i_ex_mem.mem_read;
  assign o_dmem_wen   = i_ex_mem.valid && i_ex_mem.mem_write;
  assign o_dmem_wdata = i_ex_mem.store_data;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mem_wb_q.valid <= 1'b0;
    end else begin
      mem_wb_q <= i_ex_mem;
    end
  end

  // writes to x0 count as no write at all
  assign o_wb_valid = mem_wb_q.valid && mem_wb_q.reg_write && mem_wb_q.inst.rd != '0;
  assign o_wb_addr  = mem_wb_q.inst.rd;
  assign o_wb_data  = (mem_wb_q.wb_sel == MEM) ? i_dmem_rdata : mem_wb_q.alu_result;

  always_comb begin
    o_retire.valid     = mem_wb_q.valid;
    o_retire.halt      = mem_wb_q.halt;
    o_retire.inst      = mem_wb_q.inst;
    o_retire.pc        = mem_wb_q.pc;
    o_retire.rd_addr   = o_wb_valid ? mem_wb_q.inst.rd : '0;
    o_retire.rd_data   = o_wb_valid ? o_wb_data : '0;
    o_retire.rs1_data  = mem_wb_q.rs1_val;
    o_retire.rs2_data  = mem_wb_q.rs2_val;
    o_retire.dmem_addr = mem_wb_q.alu_result;
    o_retire.dmem_ren  = mem_wb_q.valid && mem_wb_q.mem_read;  // what the port saw last cycle
    o_retire.dmem_wen  = mem_wb_q.valid && mem_wb_q.mem_write;
  end

endmodule

// File: verilog/hart_top.sv
`timescale 1ns/100ps
`include "hart_params.svh"

module hart_top (
  input  logic              i_clk,
  input  logic              i_rst,
  output logic [`XLEN-1:0]  o_imem_raddr,
  input  logic [`XLEN-1:0]  i_imem_rdata,
  output logic [`XLEN-1:0]  o_dmem_addr,
  output logic              o_dmem_ren,
  output logic              o_dmem_wen,
  output logic [`XLEN-1:0]  o_dmem_wdata,
  input  logic [`XLEN-1:0]  i_dmem_rdata,
  output pipe_pkg::retire_t o_retire
);
  import pipe_pkg::*;

  if_id_t             if_id;
  id_ex_t             id_ex;
  ex_mem_t            ex_mem;
  logic               stall;
  logic               halt_seen;
  logic [`REG_AW-1:0] ex_rd;
  logic               ex_mem_read;
  logic               wb_valid;    // writeback port shared by decode and execute
  logic [`REG_AW-1:0] wb_addr;
  logic [`XLEN-1:0]   wb_data;

  fetch_stage u_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_stall      (stall),
    .i_halt_seen  (halt_seen),
    .i_imem_rdata (i_imem_rdata),
    .o_imem_raddr (o_imem_raddr),
    .o_if_id      (if_id)
  );

  decode_stage u_decode (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_if_id       (if_id),
    .i_ex_rd       (ex_rd),
    .i_ex_mem_read (ex_mem_read),
    .i_wb_valid    (wb_valid),
    .i_wb_addr     (wb_addr),
    .i_wb_data     (wb_data),
    .o_stall       (stall),
    .o_halt_seen   (halt_seen),
    .o_id_ex       (id_ex)
  );

  execute_stage u_execute (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_id_ex       (id_ex),
    .i_wb_valid    (wb_valid),
    .i_wb_addr     (wb_addr),
    .i_wb_data     (wb_data),
    .o_ex_rd       (ex_rd),
    .o_ex_mem_read (ex_mem_read),
    .o_ex_mem      (ex_mem)
  );

  mem_wb_stage u_mem_wb (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_ex_mem     (ex_mem),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_ren   (o_dmem_ren),
    .o_dmem_wen   (o_dmem_wen),
    .o_dmem_wdata (o_dmem_wdata),
    .o_wb_valid   (wb_valid),
    .o_wb_addr    (wb_addr),
    .o_wb_data    (wb_data),
    .o_retire     (o_retire)
  );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic o_clk,
  output logic o_rst
);
  localparam int half_period = 10; // 20 ns clock

  initial begin
    o_clk = 1'b0;
    forever #half_period o_clk = ~o_clk;
  end

  // reset is seen by three rising edges and drops on a falling edge like the other inputs
  initial begin
    o_rst = 1'b1;
    repeat (3) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

// File: bench/hart_assert.sv
`timescale 1ns/100ps

module hart_assert (
  input logic              i_clk,
  input logic              i_rst,
  input logic              i_dmem_ren,
  input logic              i_dmem_wen,
  input pipe_pkg::retire_t i_retire
);
  logic halted_q;         // an ebreak has retired since reset
  int   failures = 0;     // read by the testbench summary

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      halted_q <= 1'b0;
    end else if (i_retire.valid && i_retire.halt) begin
      halted_q <= 1'b1;
    end
  end

  // one word access per cycle, a load or a store but never both
  one_dmem_access: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_dmem_ren && i_dmem_wen))
    else begin
      $error("dmem read and write enables are high in the same cycle");
      failures++;
    end

  // from the second reset edge on the stage registers hold their cleared values
  quiet_in_reset: assert property (@(posedge i_clk) i_rst && $past(i_rst) |-> !i_retire.valid)
    else begin
      $error("an instruction retires while reset is held");
      failures++;
    end

  nothing_after_halt: assert property (@(posedge i_clk) disable iff (i_rst)
    halted_q |-> !i_retire.valid)
    else begin
      $error("an instruction retires after the ebreak");
      failures++;
    end

endmodule

bind hart_top hart_assert u_hart_assert (
  .i_clk      (i_clk),
  .i_rst      (i_rst),
  .i_dmem_ren (o_dmem_ren),
  .i_dmem_wen (o_dmem_wen),
  .i_retire   (o_retire)
);

// File: bench/tb_top.sv
`timescale 1ns/100ps
`include "hart_params.svh"

module tb_top;
  import pipe_pkg::*;

  localparam int n_inst       = 200;            // random instructions before the ebreak
  localparam int cycle_limit  = 2 * n_inst + 50; // at most two cycles per instruction
  localparam int drain_cycles = 10;             // watch for stray retires after the halt

  logic             clk;
  logic             rst;
  logic [`XLEN-1:0] imem_raddr;
  logic [`XLEN-1:0] imem_rdata;
  logic [`XLEN-1:0] dmem_addr;
  logic             dmem_ren;
  logic             dmem_wen;
  logic [`XLEN-1:0] dmem_wdata;
  logic [`XLEN-1:0] dmem_rdata;
  retire_t          retire;

  logic [31:0] imem [256];
  logic [31:0] dmem [64];        // the 64-word data region at address 0
  logic [31:0] exp_dmem [64];    // data memory as the sequential model leaves it
  logic [31:0] imem_addr_q = '0; // read addresses taken at the rising edge
  logic [31:0] dmem_addr_q = '0;
  retire_t     exp_q [$];        // one expected retire per instruction, in program order
  integer      seed;
  int          errors = 0;
  int          checks = 0;
  int          retired = 0;
  int          cycles = 0;       // rising edges since reset was released
  int          reset_edges = 0;
  logic        halt_retired = 1'b0;
  int          reset_errors;
  int          run_errors;
  int          halt_errors;

  tb_clock u_clock (
    .o_clk (clk),
    .o_rst (rst)
  );

  hart_top DUT (
    .i_clk        (clk),
    .i_rst        (rst),
    .o_imem_raddr (imem_raddr),
    .i_imem_rdata (imem_rdata),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_ren   (dmem_ren),
    .o_dmem_wen   (dmem_wen),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata),
    .o_retire     (retire)
  );

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // filler for both memories, every address bit takes part
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  // op numbering: add sub and or xor slt sltu sll srl sra
  function automatic logic [31:0] model_alu(input int unsigned op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      0:       return a + b;
      1:       return a - b;
      2:       return a & b;
      3:       return a | b;
      4:       return a ^ b;
      5:       return {31'b0, $signed(a) < $signed(b)};
      6:       return {31'b0, a < b};
      7:       return a << b[4:0];
      8:       return a >> b[4:0];
      default: return 32'($signed(a) >>> b[4:0]);
    endcase
  endfunction

  function automatic logic [2:0] op_funct3(input int unsigned op);
    case (op)
      0, 1:    return 3'b000;
      2:       return 3'b111;
      3:       return 3'b110;
      4:       return 3'b100;
      5:       return 3'b010;
      6:       return 3'b011;
      7:       return 3'b001;
      default: return 3'b101; // srl and sra share it, bit 30 tells them apart
    endcase
  endfunction

  // draws the program into imem and runs it through the sequential model
  task automatic build_program();
    logic [31:0] regs [8];  // only x0 to x7 are ever named
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    logic [31:0] addr;
    logic [19:0] hi;
    logic [11:0] imm12;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int unsigned kind;
    int unsigned op;
    retire_t     e;
    for (int w = 0; w < 256; w++) begin
      imem[w] = fill_word(32'(w * 4)); // words past the ebreak must never retire
    end
    for (int w = 0; w < 64; w++) begin
      dmem[w]     = fill_word(32'(w * 4));
      exp_dmem[w] = dmem[w];
    end
    for (int r = 0; r < 8; r++) begin
      regs[r] = '0; // the hart clears its register file in reset
    end
    for (int i = 0; i < n_inst; i++) begin
      kind  = pick(8);
      rd    = 5'(pick(8));
      rs1   = 5'(pick(8));
      rs2   = 5'(pick(8));
      imm12 = 12'(pick(4096));
      hi    = 20'(pick(32'h10_0000));
      addr  = 32'(pick(64) * 4);  // word aligned, x0 is the base
      a     = regs[rs1[2:0]];
      b     = regs[rs2[2:0]];
      e       = '0;
      e.valid = 1'b1;
      e.pc    = 32'(i * 4);
      if (kind < 3) begin // register-register
        op   = pick(10);
        inst = {(op == 1 || op == 9) ? 7'h20 : 7'h00, rs2, rs1, op_funct3(op), rd, 7'h33};
        v    = model_alu(op, a, b);
        e.rs1_data = a;
        e.rs2_data = b;
      end else if (kind < 5) begin // register-immediate, no subi
        op = pick(9);
        if (op >= 1) op++;
        if (op >= 7) imm12 = {(op == 9) ? 7'h20 : 7'h00, imm12[4:0]}; // shamt form
        inst = {imm12, rs1, op_funct3(op), rd, 7'h13};
        v    = model_alu(op, a, {{20{imm12[11]}}, imm12});
        e.rs1_data = a;
      end else if (kind == 5) begin // lui
        inst = {hi, rd, 7'h37};
        v    = {hi, 12'h000};
      end else if (kind == 6) begin // lw from x0 plus offset
        inst = {addr[11:0], 5'd0, 3'b010, rd, 7'h03};
        v    = exp_dmem[addr[7:2]];
        e.dmem_addr = addr;
        e.dmem_ren  = 1'b1;
      end else begin // sw of rs2 to x0 plus offset
        inst = {addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], 7'h23};
        exp_dmem[addr[7:2]] = b;
        e.dmem_addr = addr;
        e.dmem_wen  = 1'b1;
        e.rs2_data  = b;
      end
      if (kind < 7 && rd != 5'd0) begin // x0 writes vanish and show rd_addr 0
        regs[rd[2:0]] = v;
        e.rd_addr = rd;
        e.rd_data = v;
      end
      e.inst  = inst;
      imem[i] = inst;
      exp_q.push_back(e);
    end
    e       = '0;
    e.valid = 1'b1;
    e.halt  = 1'b1;
    e.inst  = `EBREAK_INST;
    e.pc    = 32'(n_inst * 4);
    imem[n_inst] = `EBREAK_INST;
    exp_q.push_back(e);
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_idle(input string when);
    compare_field({when, " retire valid"}, 32'(retire.valid), 32'd0);
    compare_field({when, " dmem_ren"}, 32'(dmem_ren), 32'd0);
    compare_field({when, " dmem_wen"}, 32'(dmem_wen), 32'd0);
  endtask

  // the head of the model queue must match every retire, in order
  task automatic check_retire();
    retire_t e;
    assert (!halt_retired) else begin
      $display("time %0t: the instruction at pc %h retired after the ebreak", $time, retire.pc);
      errors++;
    end
    if (!halt_retired) begin
      assert (exp_q.size() != 0) else begin
        $display("time %0t: a retire at pc %h that the model never issued", $time, retire.pc);
        errors++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        compare_field("pc", retire.pc, e.pc);
        compare_field("inst", retire.inst, e.inst);
        compare_field("halt", 32'(retire.halt), 32'(e.halt));
        compare_field("rd_addr", 32'(retire.rd_addr), 32'(e.rd_addr));
        if (e.rd_addr != '0) compare_field("rd_data", retire.rd_data, e.rd_data);
        compare_field("rs1_data", retire.rs1_data, e.rs1_data);
        compare_field("rs2_data", retire.rs2_data, e.rs2_data);
        compare_field("dmem_ren", 32'(retire.dmem_ren), 32'(e.dmem_ren));
        compare_field("dmem_wen", 32'(retire.dmem_wen), 32'(e.dmem_wen));
        if (e.dmem_ren || e.dmem_wen) compare_field("dmem_addr", retire.dmem_addr, e.dmem_addr);
      end
      // the hart's own halt ends the program, every retire before it has been counted
      if (retire.halt) begin
        compare_field("retires before the ebreak", 32'(retired), 32'(n_inst));
        halt_retired = 1'b1;
      end
      retired++;
    end
  endtask

  // memories and checks see the values that settled before the rising edge
  always @(posedge clk) begin
    imem_addr_q = imem_raddr;
    if (dmem_ren) dmem_addr_q = dmem_addr;
    if (dmem_wen) dmem[dmem_addr[7:2]] = dmem_wdata;
    if (rst) begin
      reset_edges++;
      if (reset_edges > 1) check_idle("reset"); // nothing is cleared before the first edge
    end else begin
      cycles++;
      if (cycles == 1) begin
        check_idle("first cycle");
        compare_field("first fetch address", imem_raddr, `RESET_ADDR);
      end
      if (retire.valid) check_retire();
      if (cycles >= cycle_limit) begin
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
      end
    end
  end

  // both memories answer one cycle after the request, on the falling edge
  always @(negedge clk) begin
    imem_rdata <= imem[imem_addr_q[9:2]];
    dmem_rdata <= dmem[dmem_addr_q[7:2]];
  end

  initial begin
    imem_rdata = '0;
    dmem_rdata = '0;
    seed       = 32'hf89d;
    build_program();
    @(negedge rst);
    @(negedge clk);
    reset_errors = errors;
    $display("[reset] idle outputs and first fetch address checked, %0d errors", reset_errors);
    wait (halt_retired);
    @(negedge clk);
    run_errors = errors - reset_errors;
    $display("[program] %0d instructions retired, %0d errors", retired, run_errors);
    repeat (drain_cycles) @(negedge clk);
    halt_errors = errors - reset_errors - run_errors;
    $display("[halt] %0d quiet cycles after the ebreak, %0d errors", drain_cycles, halt_errors);
    for (int w = 0; w < 64; w++) begin
      compare_field($sformatf("dmem word %0d", w), dmem[w], exp_dmem[w]);
    end
    $display("[memory] 64 data words compared with the model, %0d errors",
             errors - reset_errors - run_errors - halt_errors);
    $display("checks %0d, errors %0d, assertion failures %0d, cycles %0d", checks, errors,
             DUT.u_hart_assert.failures, cycles);
    if (errors == 0 && DUT.u_hart_assert.failures == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/hart_top.sv
bench/tb_clock.sv
bench/hart_assert.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
# builds the hart testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f list.f --top-module tb_top -o sim_hart
if [ $? -ne 0 ]; then
  echo "verilator build did not complete"
  exit 1
fi

# a high error limit lets the run reach its own summary after an assertion fires
out=$(./obj_dir/sim_hart +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
